// File: run_sim.sh
#!/bin/sh
# Build with Verilator and run, run from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module console_tb \
      -f sim.f -o console_sim \
   && ./obj_dir/console_sim | tee /dev/stderr | grep -q "All tests passed" \
   && echo "Simulation PASS" \
   || { echo "Simulation FAIL"; exit 1; }

// File: sim.f
verilog/console_pkg.sv
verilog/command_pkg.sv
verilog/command_decoder.sv
verilog/cursor_regs.sv
verilog/cell_writer.sv
verilog/screen_ram.sv
verilog/console_top.sv
verification/console_checker.sv
verification/console_tb.sv

// File: verification/console_checker.sv
`timescale 1ns/100ps

module console_checker
   import command_pkg::*;
(
   input logic       clk,
   input logic       rst_n,
   input dec_state_t state,
   input logic       busy,
   input logic       we,
   input logic       wr_en,
   input logic       put_req,
   input logic       clear_req,
   input logic       clear_done
);

   // ----------------------------------------------------------------------
   // Decoder and writer rules
   // ----------------------------------------------------------------------
   idle_no_write: assert property (@(posedge clk) disable iff (!rst_n)
      (state == idle) |-> !wr_en)
      else $error("write port active while the decoder is idle");

   // A parameter strobe is taken at once and the decoder stays ready
   at_wait_ready: assert property (@(posedge clk) disable iff (!rst_n)
      (state inside {at_row, at_col}) && we |=> !busy && (state != $past(state)))
      else $error("At parameter not taken or busy raised during the wait");

   done_releases: assert property (@(posedge clk) disable iff (!rst_n)
      clear_done |=> !busy)
      else $error("busy still high after the clear sweep ended");

   one_request: assert property (@(posedge clk) disable iff (!rst_n)
      (put_req || clear_req) |-> !(put_req && clear_req) && !wr_en)
      else $error("request raised together with another or while a write is in flight");

endmodule

bind console_top console_checker chk0 (
   .clk(clk), .rst_n(rst_n), .state(u_decoder.state), .busy(busy), .we(we),
   .wr_en(wr_en), .put_req(put_req), .clear_req(clear_req), .clear_done(clear_done)
);

// File: verification/console_tb.sv
`timescale 1ns/100ps

module console_tb
   import console_pkg::*;
   import command_pkg::*;
();

   localparam int n_fixed  = 16;
   localparam int n_filler = 40;
   localparam int n_ent    = n_fixed + n_filler;

   logic       clk;
   logic       rst_n;
   char_t      chr;
   logic       we;
   cell_addr_t fetch_addr;
   logic       busy;
   char_t      fetch_char;
   cell_addr_t cursor;

   // Directed part of the table with each byte and the cursor once it has taken effect
   char_t fix_byte [n_fixed] = '{
      8'd12, 8'h48, 8'h69, 8'd13, 8'd22, 8'h25, 8'h47, 8'h41,
      8'd22, 8'h0f, 8'h3f, 8'h5a, 8'd22, 8'h1f, 8'h05, 8'd13
   };
   cell_addr_t fix_cursor [n_fixed] = '{
      9'd0, 9'd1, 9'd2, 9'd32, 9'd32, 9'd32, 9'd167, 9'd168,
      9'd168, 9'd168, 9'd511, 9'd0, 9'd0, 9'd0, 9'd485, 9'd0
   };

   char_t            tbl_byte [n_ent];
   cell_addr_t       tbl_cursor [n_ent];
   char_t            scr_model [cell_count];  // Reference screen
   cell_addr_t       cur_model;
   logic [row_w-1:0] row_model;
   int               at_phase;                // Row due at 1 and column due at 2
   int               errors;
   int               seed;
   int               exp_busy;
   int               n_busy;

   console_top dut0 (
      .clk(clk), .rst_n(rst_n), .chr(chr), .we(we), .fetch_addr(fetch_addr),
      .busy(busy), .fetch_char(fetch_char), .cursor(cursor)
   );

   always #10 clk = ~clk;

   task automatic build_table();
      int r;
      for (int i = 0; i < n_fixed; i++) begin
         tbl_byte[i]   = fix_byte[i];
         tbl_cursor[i] = fix_cursor[i];
      end
      // Filler words start at cell 0 after the last carriage return
      for (int k = 0; k < n_filler; k++) begin
         r = $random(seed);
         if (k % 5 == 4)
            tbl_byte[n_fixed+k] = 8'h20;
         else
            tbl_byte[n_fixed+k] = char_t'(32'h21 + ((r & 32'h7fff_ffff) % 94));
         tbl_cursor[n_fixed+k] = cell_addr_t'(k + 1);
      end
   endtask

   // Reference behavior and busy length of one accepted byte
   task automatic model_byte(input char_t b, output int nb);
      if (at_phase == 1) begin
         row_model = b[row_w-1:0];
         at_phase  = 2;
         nb        = 0;
      end else if (at_phase == 2) begin
         cur_model = cell_addr_t'(int'(row_model) * cols + int'(b[col_w-1:0]));
         at_phase  = 0;
         nb        = 0;
      end else if (b == code_at) begin
         at_phase = 1;
         nb       = 1;
      end else if (b == code_cr) begin
         cur_model = cell_addr_t'(((int'(cur_model) / cols + 1) % rows) * cols);
         nb        = 1;
      end else if (b == code_home) begin
         for (int a = 0; a < cell_count; a++)
            scr_model[a] = blank_char;
         cur_model = '0;
         nb        = 513;
      end else begin
         scr_model[cur_model] = b;
         cur_model = cur_model + 9'd1;  // 511 wraps to 0
         nb        = 2;
      end
   endtask

   task automatic wait_ready();
      @(negedge clk);
      while (busy)
         @(negedge clk);
   endtask

   // Offer one byte and optionally hold we with a second byte while busy
   task automatic send_byte(input char_t b, input char_t intr, input logic intrude,
                            output int nb);
      wait_ready();
      @(posedge clk);
      chr <= b;
      we  <= 1'b1;
      @(posedge clk);                 // Accepted here
      chr <= intrude ? intr : b;
      we  <= intrude;
      nb = 0;
      @(negedge clk);
      while (busy) begin
         nb++;
         @(posedge clk);
         we <= 1'b0;
         @(negedge clk);
      end
      @(negedge clk);                 // Parameters land one cycle late
   endtask

   task automatic check_step(input string tag, input cell_addr_t exp_cur, input int nb,
                             input int exp_nb);
      if (cursor !== exp_cur) begin
         $display("ERR %0t: %s cursor %0d, expected %0d", $time, tag, cursor, exp_cur);
         errors++;
      end
      if (exp_nb == 513 ? (nb < 513 || nb > 514) : (nb != exp_nb)) begin
         $display("ERR %0t: %s busy for %0d cycles, expected %0d", $time, tag, nb, exp_nb);
         errors++;
      end
   endtask

   // Pipelined fetch of one address per cycle
   task automatic compare_screen(input string tag);
      for (int a = 0; a <= cell_count; a++) begin
         @(posedge clk);
         if (a < cell_count)
            fetch_addr <= cell_addr_t'(a);
         @(negedge clk);
         if (a > 0 && fetch_char !== scr_model[a-1]) begin
            $display("ERR %0t: %s cell %0d holds %h, expected %h", $time, tag, a - 1,
                     fetch_char, scr_model[a-1]);
            errors++;
         end
      end
   endtask

   // ----------------------------------------------------------------------
   // Main sequence
   // ----------------------------------------------------------------------
   initial begin
      clk        = 1'b0;
      rst_n      = 1'b0;
      chr        = '0;
      we         = 1'b0;
      fetch_addr = '0;
      seed       = 32'h6599_dbb6;
      errors     = 0;
      at_phase   = 0;
      cur_model  = '0;
      row_model  = '0;
      build_table();

      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      if (busy !== 1'b0 || cursor !== '0) begin
         $display("ERR %0t: after reset busy %b cursor %0d", $time, busy, cursor);
         errors++;
      end

      for (int i = 0; i < n_ent; i++) begin
         model_byte(tbl_byte[i], exp_busy);
         send_byte(tbl_byte[i], 8'h00, 1'b0, n_busy);
         check_step($sformatf("entry %0d", i), tbl_cursor[i], n_busy, exp_busy);
         if (exp_busy == 513)
            compare_screen("after home");
      end
      compare_screen("after table");

      // Second byte offered during a put and then during a Home
      model_byte(8'h51, exp_busy);
      send_byte(8'h51, 8'h58, 1'b1, n_busy);
      check_step("put with extra strobe", cur_model, n_busy, exp_busy);
      compare_screen("after put with extra strobe");
      model_byte(code_home, exp_busy);
      send_byte(code_home, 8'h58, 1'b1, n_busy);
      check_step("home with extra strobe", cur_model, n_busy, exp_busy);
      compare_screen("after home with extra strobe");

      $display("Errors: %0d", errors);
      if (errors == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

   // Watchdog
   initial begin
      repeat (n_ent * 600 + 2000) @(posedge clk);
      $display("Timeout: the run did not finish within the cycle limit");
      $display("Some tests failed");
      $finish;
   end

endmodule

// File: verilog/cell_writer.sv
`timescale 1ns/100ps

module cell_writer
   import console_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       put_req,
   input  char_t      put_char,
   input  logic       clear_req,
   input  cell_addr_t cursor,
   output logic       wr_en,
   output cell_addr_t wr_addr,
   output char_t      wr_data,
   output logic       clear_done
);

   logic       put_en;     // Single write pending
   cell_addr_t put_addr;
   char_t      put_data;
   logic       sweeping;   // Clear sweep active
   cell_addr_t sweep_cnt;

   // ----------------------------------------------------------------------
   // Control
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         put_en    <= 1'b0;
         sweeping  <= 1'b0;
         sweep_cnt <= '0;
      end else begin
         put_en <= put_req;
         if (clear_req) begin
            sweeping  <= 1'b1;
            sweep_cnt <= '0;
         end else if (sweeping) begin
            if (clear_done)
               sweeping <= 1'b0;
            sweep_cnt <= sweep_cnt + 1'b1;
         end
      end
   end

   // Payload of a single put
   always_ff @(posedge clk) begin
      if (put_req) begin
         put_addr <= cursor;
         put_data <= put_char;
      end
   end

   // Sweep owns the port while it runs
   assign wr_en   = put_en || sweeping;
   assign wr_addr = sweeping ? sweep_cnt : put_addr;
   assign wr_data = sweeping ? blank_char : put_data;

   assign clear_done = sweeping && (sweep_cnt == cell_addr_t'(cell_count - 1));

endmodule

// File: verilog/command_decoder.sv
`timescale 1ns/100ps

module command_decoder
   import console_pkg::*;
   import command_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  char_t chr,
   input  logic  we,
   input  logic  clear_done,
   output logic  busy,
   output logic  put_req,
   output char_t put_char,
   output logic  clear_req,
   output logic  advance,
   output logic  newline,
   output logic  home,
   output logic  load_row,
   output logic  load_col,
   output char_t param
);

   dec_state_t state;
   char_t      byte_q;     // Last accepted byte
   logic       accept;
   logic       is_at;
   logic       is_cr;
   logic       is_home;

   // Parameter bytes are taken without raising busy
   assign busy   = !(state inside {idle, at_row, at_col});
   assign accept = we && !busy;

   assign is_at   = (byte_q == code_at);
   assign is_cr   = (byte_q == code_cr);
   assign is_home = (byte_q == code_home);

   // ----------------------------------------------------------------------
   // State register
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= idle;
         load_row <= 1'b0;
         load_col <= 1'b0;
      end else begin
         // Row and column take effect one cycle after acceptance
         load_row <= accept && (state == at_row);
         load_col <= accept && (state == at_col);

         case (state)
            idle:    if (accept) state <= decode;
            decode: begin
               if (is_at)
                  state <= at_row;
               else if (is_cr)
                  state <= idle;
               else if (is_home)
                  state <= clear;
               else
                  state <= put;
            end
            at_row:  if (accept) state <= at_col;
            at_col:  if (accept) state <= idle;
            put:     state <= idle;          // Write lands, cursor moves on
            clear:   if (clear_done) state <= idle;
            default: state <= idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept)
         byte_q <= chr;
   end

   // ----------------------------------------------------------------------
   // One-cycle strobes
   // ----------------------------------------------------------------------
   assign put_req   = (state == decode) && !(is_at || is_cr || is_home);
   assign clear_req = (state == decode) && is_home;
   assign home      = (state == decode) && is_home;
   assign newline   = (state == decode) && is_cr;
   assign advance   = (state == put);

   assign put_char = byte_q;
   assign param    = byte_q;  // Low bits give row or column

endmodule

// File: verilog/command_pkg.sv
package command_pkg;

   // ----------------------------------------------------------------------
   // Control codes seen on the host byte stream
   // ----------------------------------------------------------------------
   localparam logic [7:0] code_at   = 8'd22;  // Followed by row, then column
   localparam logic [7:0] code_cr   = 8'd13;  // Start of next row
   localparam logic [7:0] code_home = 8'd12;  // Clear screen, cursor to 0

   // ----------------------------------------------------------------------
   // Decoder states
   // ----------------------------------------------------------------------
   typedef enum logic [2:0] {
      idle,    // Waiting for a byte
      decode,  // Classify the latched byte
      at_row,  // Waiting for the row parameter
      at_col,  // Waiting for the column parameter
      put,     // Cell write in flight
      clear    // Clear sweep running
   } dec_state_t;

endpackage

// File: verilog/console_pkg.sv
package console_pkg;

   // ----------------------------------------------------------------------
   // Screen geometry
   // ----------------------------------------------------------------------
   localparam int cols       = 32;   // Characters per row
   localparam int rows       = 16;   // Text rows
   localparam int cell_count = cols * rows;

   localparam int col_w = $clog2(cols);  // Column field width
   localparam int row_w = $clog2(rows);  // Row field width

   // ----------------------------------------------------------------------
   // Cell and address types
   // ----------------------------------------------------------------------

   // Row sits in the upper bits, column in the lower bits
   typedef logic [row_w+col_w-1:0] cell_addr_t;

   typedef logic [7:0] char_t;

   // Written to every cell by a Home
   localparam char_t blank_char = 8'h20;

endpackage

// File: verilog/console_top.sv
`timescale 1ns/100ps

module console_top
   import console_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  char_t      chr,
   input  logic       we,
   input  cell_addr_t fetch_addr,
   output logic       busy,
   output char_t      fetch_char,
   output cell_addr_t cursor
);

   logic       put_req;
   char_t      put_char;
   logic       clear_req;
   logic       clear_done;
   logic       advance;
   logic       newline;
   logic       home;
   logic       load_row;
   logic       load_col;
   char_t      param;
   logic       wr_en;
   cell_addr_t wr_addr;
   char_t      wr_data;

   // ----------------------------------------------------------------------
   // Write side
   // ----------------------------------------------------------------------
   command_decoder u_decoder (
      .clk(clk), .rst_n(rst_n), .chr(chr), .we(we), .clear_done(clear_done),
      .busy(busy), .put_req(put_req), .put_char(put_char), .clear_req(clear_req),
      .advance(advance), .newline(newline), .home(home), .load_row(load_row),
      .load_col(load_col), .param(param)
   );

   cursor_regs u_cursor (
      .clk(clk), .rst_n(rst_n), .advance(advance), .newline(newline),
      .home(home), .load_row(load_row), .load_col(load_col), .param(param),
      .cursor(cursor)
   );

   cell_writer u_writer (
      .clk(clk), .rst_n(rst_n), .put_req(put_req), .put_char(put_char),
      .clear_req(clear_req), .cursor(cursor), .wr_en(wr_en), .wr_addr(wr_addr),
      .wr_data(wr_data), .clear_done(clear_done)
   );

   // Buffer, fetch port faces the display
   screen_ram u_ram (
      .clk(clk), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
      .fetch_addr(fetch_addr), .fetch_char(fetch_char)
   );

endmodule

// File: verilog/cursor_regs.sv
`timescale 1ns/100ps

module cursor_regs
   import console_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       advance,
   input  logic       newline,
   input  logic       home,
   input  logic       load_row,
   input  logic       load_col,
   input  char_t      param,
   output cell_addr_t cursor
);

   logic [row_w-1:0] row_latch;  // Row from the first At parameter
   logic [row_w-1:0] next_row;

   // Row wraps from the last row back to 0
   assign next_row = cursor[row_w+col_w-1:col_w] + 1'b1;

   // ----------------------------------------------------------------------
   // Cursor position
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cursor <= '0;
      end else begin
         if (home)
            cursor <= '0;
         else if (load_col)
            cursor <= {row_latch, param[col_w-1:0]};
         else if (newline)
            cursor <= {next_row, {col_w{1'b0}}};
         else if (advance)
            cursor <= cursor + 1'b1;  // 511 rolls over to 0
      end
   end

   // Pending row for the At sequence
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         row_latch <= '0;
      end else if (load_row) begin
         row_latch <= param[row_w-1:0];
      end
   end

endmodule

// File: verilog/screen_ram.sv
`timescale 1ns/100ps

module screen_ram
   import console_pkg::*;
(
   input  logic       clk,
   input  logic       wr_en,
   input  cell_addr_t wr_addr,
   input  char_t      wr_data,
   input  cell_addr_t fetch_addr,
   output char_t      fetch_char
);

   char_t mem [cell_count];  // One byte per character cell

   // Same-cell read and write returns the old byte
   always_ff @(posedge clk) begin
      if (wr_en)
         mem[wr_addr] <= wr_data;
      fetch_char <= mem[fetch_addr];
   end

endmodule
